// ==== design/soc_cfg.svh ====
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

`default_nettype none

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define SOC_DATA_W      32 // Data word
`define SOC_ADDR_W      16 // Host address
`define SOC_OFFS_W      12 // Word offset inside a region
`define SOC_REGION_W    4  // Region field on top of the address

// ----------------------------------------
// Slave sizes
// ----------------------------------------
`define SOC_SRAM_DEPTH  64 // SRAM words
`define SOC_GPIO_W      16 // GPIO pins
`define SOC_SYNC_STAGES 2  // Input synchronizer flops

`default_nettype wire

`endif

// ==== design/soc_bus_pkg.sv ====
`include "soc_cfg.svh"

`default_nettype none

package soc_bus_pkg;

	// Address map, one region per slave
	typedef enum logic [`SOC_REGION_W-1:0] {
		REGION_SRAM  = 4'd0,
		REGION_TIMER = 4'd1,
		REGION_GPIO  = 4'd2
	} region_e;

	typedef struct packed {
		region_e                 region; // Upper nibble picks the slave
		logic [`SOC_OFFS_W-1:0]  offset; // Word offset
	} bus_fields_t;

	// Same address word, seen whole by the host and by fields in the controller
	typedef union packed {
		logic [`SOC_ADDR_W-1:0] raw;
		bus_fields_t            fields;
	} bus_addr_u;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_ACCESS = 2'd1,
		ST_RESP   = 2'd2
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/soc_periph_pkg.sv ====
`default_nettype none

package soc_periph_pkg;

	// Timer register map, word offsets
	typedef enum logic [1:0] {
		TMR_LOAD   = 2'd0,
		TMR_VALUE  = 2'd1,
		TMR_CTRL   = 2'd2,
		TMR_STATUS = 2'd3
	} timer_reg_e;

	// GPIO register map, word offsets
	typedef enum logic [1:0] {
		GPIO_OUT = 2'd0,
		GPIO_DIR = 2'd1,
		GPIO_ALT = 2'd2,
		GPIO_IN  = 2'd3 // Read only
	} gpio_reg_e;

	localparam int TMR_CTRL_EN_BIT    = 0; // Count enable
	localparam int TMR_CTRL_IRQEN_BIT = 1; // Interrupt enable

endpackage

`default_nettype wire

// ==== design/periph_bus_if.sv ====
`include "soc_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;

	// Controller to slaves
	logic                   sram_sel;
	logic                   timer_sel;
	logic                   gpio_sel;
	logic                   we;
	logic [`SOC_OFFS_W-1:0] offset;
	logic [`SOC_DATA_W-1:0] wdata;

	// Slaves to controller, registered in each slave
	logic [`SOC_DATA_W-1:0] sram_rdata;
	logic [`SOC_DATA_W-1:0] timer_rdata;
	logic [`SOC_DATA_W-1:0] gpio_rdata;

	modport ctrl (
		output sram_sel, timer_sel, gpio_sel, we, offset, wdata,
		input  sram_rdata, timer_rdata, gpio_rdata
	);

	modport sram  (input sram_sel, we, offset, wdata, output sram_rdata);
	modport timer (input timer_sel, we, offset, wdata, output timer_rdata);
	modport gpio  (input gpio_sel, we, offset, wdata, output gpio_rdata);

endinterface

`default_nettype wire

// ==== design/bus_ctrl_fsm.sv ====
`include "soc_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module bus_ctrl_fsm (
	input  logic                   hclk_i,
	input  logic                   rst_n_i,
	input  logic                   req_i,
	input  logic                   we_i,
	input  soc_bus_pkg::bus_addr_u addr_i,
	input  logic [`SOC_DATA_W-1:0] wdata_i,
	output logic                   resp_valid_o,
	output logic                   resp_err_o,
	output logic [`SOC_DATA_W-1:0] rdata_o,
	periph_bus_if.ctrl             bus_o
);
	import soc_bus_pkg::*;

	ctrl_state_e            state_q;
	ctrl_state_e            state_d;
	bus_addr_u              addr_q;
	logic                   we_q;
	logic [`SOC_DATA_W-1:0] wdata_q;
	logic                   in_access;
	logic                   region_ok;

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	always_comb begin
		case (state_q)
			ST_IDLE:   state_d = req_i ? ST_ACCESS : ST_IDLE;
			ST_ACCESS: state_d = ST_RESP;
			default:   state_d = ST_IDLE; // ST_RESP and unused code
		endcase
	end

	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Request is taken only in idle
	always_ff @(posedge hclk_i) begin
		if (state_q == ST_IDLE && req_i) begin
			addr_q.raw <= addr_i.raw;
			we_q       <= we_i;
			wdata_q    <= wdata_i;
		end
	end

	// ----------------------------------------
	// Address decode
	// ----------------------------------------
	assign in_access = (state_q == ST_ACCESS);
	assign region_ok = addr_q.fields.region inside {REGION_SRAM, REGION_TIMER, REGION_GPIO};

	assign bus_o.sram_sel  = in_access && (addr_q.fields.region == REGION_SRAM);
	assign bus_o.timer_sel = in_access && (addr_q.fields.region == REGION_TIMER);
	assign bus_o.gpio_sel  = in_access && (addr_q.fields.region == REGION_GPIO);
	assign bus_o.we        = we_q;
	assign bus_o.offset    = addr_q.fields.offset;
	assign bus_o.wdata     = wdata_q;

	// ----------------------------------------
	// Response
	// ----------------------------------------
	assign resp_valid_o = (state_q == ST_RESP);
	assign resp_err_o   = (state_q == ST_RESP) && !region_ok;

	always_comb begin
		rdata_o = '0; // Writes and errors return zero
		if (state_q == ST_RESP && !we_q) begin
			case (addr_q.fields.region)
				REGION_SRAM:  rdata_o = bus_o.sram_rdata;
				REGION_TIMER: rdata_o = bus_o.timer_rdata;
				REGION_GPIO:  rdata_o = bus_o.gpio_rdata;
				default:      rdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/data_sram.sv ====
`include "soc_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module data_sram (
	input  logic        hclk_i,
	periph_bus_if.sram  bus_i
);

	localparam int IDX_W = $clog2(`SOC_SRAM_DEPTH);

	logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_DEPTH];
	logic [`SOC_DATA_W-1:0] rdata_q;
	logic [IDX_W-1:0]       idx;

	assign idx = bus_i.offset[IDX_W-1:0]; // Upper offset bits alias

	always_ff @(posedge hclk_i) begin
		if (bus_i.sram_sel) begin
			if (bus_i.we) begin
				mem[idx] <= bus_i.wdata;
			end
			rdata_q <= mem[idx]; // Old contents on a write
		end
	end

	assign bus_i.sram_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== design/tick_timer.sv ====
`include "soc_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module tick_timer (
	input  logic        hclk_i,
	input  logic        rst_n_i,
	periph_bus_if.timer bus_i,
	output logic        irq_o,
	output logic        tick_o
);
	import soc_periph_pkg::*;

	logic [`SOC_DATA_W-1:0] load_q;
	logic [`SOC_DATA_W-1:0] value_q;
	logic [1:0]             ctrl_q;
	logic                   status_q;
	logic                   tick_q;
	logic [`SOC_DATA_W-1:0] rdata_q;
	timer_reg_e             reg_sel;
	logic                   wr_en;
	logic                   reload;

	assign reg_sel = timer_reg_e'(bus_i.offset[1:0]);
	assign wr_en   = bus_i.timer_sel && bus_i.we;
	assign reload  = ctrl_q[TMR_CTRL_EN_BIT] && (value_q == '0);

	// ----------------------------------------
	// Counter and status
	// ----------------------------------------
	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			load_q   <= '0;
			value_q  <= '0;
			ctrl_q   <= '0;
			status_q <= 1'b0;
			tick_q   <= 1'b0;
		end else begin
			if (wr_en && reg_sel == TMR_LOAD) begin
				load_q  <= bus_i.wdata;
				value_q <= bus_i.wdata; // Restart from the new value
			end else if (reload) begin
				value_q <= load_q;
			end else if (ctrl_q[TMR_CTRL_EN_BIT]) begin
				value_q <= value_q - 1'b1;
			end

			if (wr_en && reg_sel == TMR_CTRL) begin
				ctrl_q[TMR_CTRL_EN_BIT]    <= bus_i.wdata[TMR_CTRL_EN_BIT];
				ctrl_q[TMR_CTRL_IRQEN_BIT] <= bus_i.wdata[TMR_CTRL_IRQEN_BIT];
			end

			// A reload beats a clear in the same cycle
			if (reload) begin
				status_q <= 1'b1;
				tick_q   <= ~tick_q;
			end else if (wr_en && reg_sel == TMR_STATUS && bus_i.wdata[0]) begin
				status_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge hclk_i) begin
		if (bus_i.timer_sel) begin
			case (reg_sel)
				TMR_LOAD:  rdata_q <= load_q;
				TMR_VALUE: rdata_q <= value_q;
				TMR_CTRL:  rdata_q <= {{(`SOC_DATA_W-2){1'b0}}, ctrl_q};
				default:   rdata_q <= {{(`SOC_DATA_W-1){1'b0}}, status_q};
			endcase
		end
	end

	assign bus_i.timer_rdata = rdata_q;
	assign irq_o             = status_q && ctrl_q[TMR_CTRL_IRQEN_BIT];
	assign tick_o            = tick_q;

endmodule

`default_nettype wire

// ==== design/gpio_port.sv ====
`include "soc_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module gpio_port (
	input  logic                   hclk_i,
	input  logic                   rst_n_i,
	periph_bus_if.gpio             bus_i,
	input  logic                   tick_i,
	input  logic [`SOC_GPIO_W-1:0] gpio_i,
	output logic [`SOC_GPIO_W-1:0] gpio_o,
	output logic [`SOC_GPIO_W-1:0] gpio_oe_o
);
	import soc_periph_pkg::*;

	localparam int PAD_W = `SOC_DATA_W - `SOC_GPIO_W;

	logic [`SOC_GPIO_W-1:0]                       out_q;
	logic [`SOC_GPIO_W-1:0]                       dir_q;
	logic [`SOC_GPIO_W-1:0]                       alt_q;
	logic [`SOC_SYNC_STAGES-1:0][`SOC_GPIO_W-1:0] sync_q;
	logic [`SOC_DATA_W-1:0]                       rdata_q;
	gpio_reg_e                                    reg_sel;

	assign reg_sel = gpio_reg_e'(bus_i.offset[1:0]);

	// ----------------------------------------
	// Registers and input sync
	// ----------------------------------------
	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_q  <= '0;
			dir_q  <= '0;
			alt_q  <= '0;
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[`SOC_SYNC_STAGES-2:0], gpio_i}; // Shift toward the top
			if (bus_i.gpio_sel && bus_i.we) begin
				case (reg_sel)
					GPIO_OUT: out_q <= bus_i.wdata[`SOC_GPIO_W-1:0];
					GPIO_DIR: dir_q <= bus_i.wdata[`SOC_GPIO_W-1:0];
					GPIO_ALT: alt_q <= bus_i.wdata[`SOC_GPIO_W-1:0];
					default:  ; // GPIO_IN ignores writes
				endcase
			end
		end
	end

	always_ff @(posedge hclk_i) begin
		if (bus_i.gpio_sel) begin
			case (reg_sel)
				GPIO_OUT: rdata_q <= {{PAD_W{1'b0}}, out_q};
				GPIO_DIR: rdata_q <= {{PAD_W{1'b0}}, dir_q};
				GPIO_ALT: rdata_q <= {{PAD_W{1'b0}}, alt_q};
				default:  rdata_q <= {{PAD_W{1'b0}}, sync_q[`SOC_SYNC_STAGES-1]};
			endcase
		end
	end

	assign bus_i.gpio_rdata = rdata_q;

	// Timer tick replaces OUT on pins with ALT set
	assign gpio_o    = (alt_q & {`SOC_GPIO_W{tick_i}}) | (~alt_q & out_q);
	assign gpio_oe_o = dir_q;

endmodule

`default_nettype wire

// ==== design/soc_top.sv ====
`include "soc_cfg.svh"

`timescale 1ns/1ps
`default_nettype none

module soc_top (
	input  logic                   hclk_i,
	input  logic                   rst_n_i,
	input  logic                   req_i,
	input  logic                   we_i,
	input  logic [`SOC_ADDR_W-1:0] addr_i,
	input  logic [`SOC_DATA_W-1:0] wdata_i,
	output logic                   resp_valid_o,
	output logic                   resp_err_o,
	output logic [`SOC_DATA_W-1:0] rdata_o,
	output logic                   irq_o,
	input  logic [`SOC_GPIO_W-1:0] gpio_i,
	output logic [`SOC_GPIO_W-1:0] gpio_o,
	output logic [`SOC_GPIO_W-1:0] gpio_oe_o
);

	logic timer_tick; // Timer toggle to the GPIO alternate function

	periph_bus_if i_bus ();

	// ----------------------------------------
	// Controller
	// ----------------------------------------
	bus_ctrl_fsm i_ctrl (
		.hclk_i       (hclk_i),
		.rst_n_i      (rst_n_i),
		.req_i        (req_i),
		.we_i         (we_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.resp_valid_o (resp_valid_o),
		.resp_err_o   (resp_err_o),
		.rdata_o      (rdata_o),
		.bus_o        (i_bus.ctrl)
	);

	// ----------------------------------------
	// Slaves
	// ----------------------------------------
	data_sram i_sram (
		.hclk_i (hclk_i),
		.bus_i  (i_bus.sram)
	);

	tick_timer i_timer (
		.hclk_i  (hclk_i),
		.rst_n_i (rst_n_i),
		.bus_i   (i_bus.timer),
		.irq_o   (irq_o),
		.tick_o  (timer_tick)
	);

	gpio_port i_gpio (
		.hclk_i    (hclk_i),
		.rst_n_i   (rst_n_i),
		.bus_i     (i_bus.gpio),
		.tick_i    (timer_tick),
		.gpio_i    (gpio_i),
		.gpio_o    (gpio_o),
		.gpio_oe_o (gpio_oe_o)
	);

endmodule

`default_nettype wire

// ==== tests/soc_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_properties (
	input  logic hclk_i,
	input  logic rst_n_i,
	input  logic req_i,
	input  logic resp_valid_i,
	input  logic resp_err_i
);

	logic [1:0]  busy_q;            // Accepted strobes of the last two cycles
	logic        accepted;
	int unsigned violation_cnt = 0; // Failed assertions so far

	assign accepted = req_i && (busy_q == 2'b00);

	always_ff @(posedge hclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= '0;
		end else begin
			busy_q <= {busy_q[0], accepted};
		end
	end

	// ----------------------------------------
	// Response timing
	// ----------------------------------------
	resp_not_early: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		accepted |=> !resp_valid_i)
	else begin
		violation_cnt++;
		$error("resp_valid_o high one cycle after an accepted strobe");
	end

	resp_after_two: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		accepted |-> ##2 resp_valid_i)
	else begin
		violation_cnt++;
		$error("resp_valid_o missing two cycles after an accepted strobe");
	end

	err_with_valid: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		resp_err_i |-> resp_valid_i)
	else begin
		violation_cnt++;
		$error("resp_err_o high without resp_valid_o");
	end

	// ----------------------------------------
	// Host spacing
	// ----------------------------------------
	no_req_next: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		accepted |=> !req_i)
	else begin
		violation_cnt++;
		$error("Strobe one cycle after an accepted strobe");
	end

	no_req_second: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
		accepted |-> ##2 !req_i)
	else begin
		violation_cnt++;
		$error("Strobe two cycles after an accepted strobe");
	end

endmodule

`default_nettype wire

// ==== tests/soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_cfg.svh"

module soc_tb;
	import soc_bus_pkg::*;
	import soc_periph_pkg::*;

	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 3;
	localparam int ACCESS_CYCLES   = 4;  // Strobe, access, response, idle
	localparam int N_ACCESSES      = 29; // Summed over all tests
	localparam int WAIT_CYCLES     = 15 + 4 + 20;
	localparam int RUN_CYCLES      = RESET_CYCLES + N_ACCESSES * ACCESS_CYCLES + WAIT_CYCLES;
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 100;

	integer seed = 12;

	logic                   hclk;
	logic                   rst_n;
	logic                   req;
	logic                   we;
	logic [`SOC_ADDR_W-1:0] addr;
	logic [`SOC_DATA_W-1:0] wdata;
	logic                   resp_valid;
	logic                   resp_err;
	logic [`SOC_DATA_W-1:0] rdata;
	logic                   irq;
	logic [`SOC_GPIO_W-1:0] gpio_in;
	logic [`SOC_GPIO_W-1:0] gpio_out;
	logic [`SOC_GPIO_W-1:0] gpio_oe;
	logic [`SOC_GPIO_W-1:0] gpio_out_exp; // OUT value from the GPIO test

	soc_top i_soc_top (
		.hclk_i       (hclk),
		.rst_n_i      (rst_n),
		.req_i        (req),
		.we_i         (we),
		.addr_i       (addr),
		.wdata_i      (wdata),
		.resp_valid_o (resp_valid),
		.resp_err_o   (resp_err),
		.rdata_o      (rdata),
		.irq_o        (irq),
		.gpio_i       (gpio_in),
		.gpio_o       (gpio_out),
		.gpio_oe_o    (gpio_oe)
	);

	bind soc_top soc_properties i_props (
		.hclk_i       (hclk_i),
		.rst_n_i      (rst_n_i),
		.req_i        (req_i),
		.resp_valid_i (resp_valid_o),
		.resp_err_i   (resp_err_o)
	);

	initial begin
		hclk = 1'b0;
		forever #(CLK_PERIOD / 2) hclk = ~hclk;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [`SOC_ADDR_W-1:0] reg_addr(input logic [3:0] region,
			input logic [11:0] offset);
		return {region, offset}; // Region nibble on top of the word offset
	endfunction

	function automatic logic [31:0] ctrl_word(input logic en, input logic irq_en);
		logic [31:0] w;
		w                     = '0;
		w[TMR_CTRL_EN_BIT]    = en;
		w[TMR_CTRL_IRQEN_BIT] = irq_en;
		return w;
	endfunction

	// Called and left 1 ns after a rising edge
	task automatic bus_access(input logic wr, input logic [`SOC_ADDR_W-1:0] address,
			input logic [31:0] data, output logic [31:0] rd, output logic err);
		req   = 1'b1;
		we    = wr;
		addr  = address;
		wdata = data;
		@(posedge hclk);
		#1;
		req = 1'b0;
		check_value("resp_valid_o", 32'(resp_valid), 32'd0); // Still in the access cycle
		@(posedge hclk);
		#1;
		check_value("resp_valid_o", 32'(resp_valid), 32'd1);
		rd  = rdata;
		err = resp_err;
		if (wr) begin
			check_value("rdata_o", rd, 32'd0); // Writes return zero
		end
		repeat (2) begin
			@(posedge hclk);
			#1;
		end
		check_value("resp_valid_o", 32'(resp_valid), 32'd0); // One-cycle pulse
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic check_reset_state();
		check_value("resp_valid_o", 32'(resp_valid), 32'd0);
		check_value("resp_err_o", 32'(resp_err), 32'd0);
		check_value("irq_o", 32'(irq), 32'd0);
		check_value("gpio_o", 32'(gpio_out), 32'd0);
		check_value("gpio_oe_o", 32'(gpio_oe), 32'd0);
	endtask

	task automatic sram_readback();
		logic [31:0] words [8];
		logic [31:0] rd;
		logic        err;
		for (int i = 0; i < 8; i++) begin
			words[i] = $random(seed);
			bus_access(1'b1, reg_addr(REGION_SRAM, 12'(i * 9)), words[i], rd, err); // Spread 0..63
			check_value("resp_err_o", 32'(err), 32'd0);
		end
		for (int i = 0; i < 8; i++) begin
			bus_access(1'b0, reg_addr(REGION_SRAM, 12'(i * 9)), 32'd0, rd, err);
			check_value("rdata_o", rd, words[i]);
			check_value("resp_err_o", 32'(err), 32'd0);
		end
	endtask

	task automatic unmapped_region();
		logic [31:0] rd;
		logic        err;
		bus_access(1'b0, reg_addr(4'd5, 12'h010), 32'd0, rd, err);
		check_value("resp_err_o", 32'(err), 32'd1);
		check_value("rdata_o", rd, 32'd0);
		bus_access(1'b1, reg_addr(4'd5, 12'h010), 32'hA5A5_5A5A, rd, err);
		check_value("resp_err_o", 32'(err), 32'd1);
		check_value("rdata_o", rd, 32'd0);
	endtask

	task automatic timer_interrupt();
		logic [31:0] rd;
		logic        err;
		int          waited;
		bus_access(1'b1, reg_addr(REGION_TIMER, 12'(TMR_LOAD)), 32'd10, rd, err);
		bus_access(1'b1, reg_addr(REGION_TIMER, 12'(TMR_CTRL)), ctrl_word(1'b1, 1'b1), rd, err);
		waited = 0;
		while (!irq && waited < 15) begin
			@(posedge hclk);
			#1;
			waited++;
		end
		assert (irq) else begin
			$display("irq_o did not rise within 15 cycles after the timer was enabled");
			abort_run();
		end
		bus_access(1'b0, reg_addr(REGION_TIMER, 12'(TMR_VALUE)), 32'd0, rd, err);
		assert (rd <= 32'd10) else begin
			$display("[FAIL] rdata_o: timer VALUE 0x%h is above LOAD 0x%h", rd, 32'd10);
			abort_run();
		end
		// Stop counting so no reload lands on the clear
		bus_access(1'b1, reg_addr(REGION_TIMER, 12'(TMR_CTRL)), ctrl_word(1'b0, 1'b1), rd, err);
		bus_access(1'b1, reg_addr(REGION_TIMER, 12'(TMR_STATUS)), 32'd1, rd, err);
		check_value("irq_o", 32'(irq), 32'd0);
	endtask

	task automatic gpio_registers();
		logic [31:0]            rd;
		logic                   err;
		logic [`SOC_GPIO_W-1:0] dir_val;
		logic [`SOC_GPIO_W-1:0] in_val;
		gpio_out_exp = 16'($random(seed));
		dir_val      = 16'($random(seed));
		bus_access(1'b1, reg_addr(REGION_GPIO, 12'(GPIO_OUT)), 32'(gpio_out_exp), rd, err);
		bus_access(1'b1, reg_addr(REGION_GPIO, 12'(GPIO_DIR)), 32'(dir_val), rd, err);
		check_value("gpio_o", 32'(gpio_out), 32'(gpio_out_exp));
		check_value("gpio_oe_o", 32'(gpio_oe), 32'(dir_val));
		in_val  = 16'($random(seed));
		gpio_in = in_val;
		repeat (4) begin
			@(posedge hclk);
			#1;
		end
		bus_access(1'b0, reg_addr(REGION_GPIO, 12'(GPIO_IN)), 32'd0, rd, err);
		check_value("rdata_o", rd, 32'(in_val));
	endtask

	task automatic alt_function_tick();
		logic [31:0] rd;
		logic        err;
		logic        prev;
		int          changes;
		bus_access(1'b1, reg_addr(REGION_TIMER, 12'(TMR_LOAD)), 32'd3, rd, err);
		bus_access(1'b1, reg_addr(REGION_TIMER, 12'(TMR_CTRL)), ctrl_word(1'b1, 1'b0), rd, err);
		bus_access(1'b1, reg_addr(REGION_GPIO, 12'(GPIO_ALT)), 32'd1, rd, err); // Pin 0 only
		prev    = gpio_out[0];
		changes = 0;
		repeat (20) begin
			@(posedge hclk);
			#1;
			if (gpio_out[0] !== prev) begin
				changes++;
			end
			prev = gpio_out[0];
			check_value("gpio_o[15:1]", 32'(gpio_out[15:1]), 32'(gpio_out_exp[15:1]));
		end
		assert (changes >= 2) else begin
			$display("gpio_o bit 0 changed only %0d times in 20 cycles with ALT set", changes);
			abort_run();
		end
	endtask

	// ----------------------------------------
	// Sequence and watchdog
	// ----------------------------------------
	initial begin
		rst_n   = 1'b0;
		req     = 1'b0;
		we      = 1'b0;
		addr    = '0;
		wdata   = '0;
		gpio_in = '0;
		repeat (RESET_CYCLES) @(posedge hclk);
		#1;
		rst_n = 1'b1;
		check_reset_state();
		sram_readback();
		unmapped_region();
		timer_interrupt();
		gpio_registers();
		alt_function_tick();
		if (i_soc_top.i_props.violation_cnt == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("Protocol assertions failed %0d times", i_soc_top.i_props.violation_cnt);
			abort_run();
		end
	end

	initial begin
		wait (i_soc_top.i_props.violation_cnt != 0);
		$display("A protocol assertion on the host port failed");
		abort_run();
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		abort_run();
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/soc_bus_pkg.sv
design/soc_periph_pkg.sv
design/periph_bus_if.sv
design/bus_ctrl_fsm.sv
design/data_sram.sv
design/tick_timer.sv
design/gpio_port.sv
design/soc_top.sv
tests/soc_properties.sv
tests/soc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SoC testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -f vlog.f -o soc_sim

# The simulator may exit non-zero on failure, the log search decides
./obj_dir/soc_sim +verilator+error+limit+100 | tee sim.log

if grep -q "all tests passed" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED"
	exit 1
fi
